//--- design/dualIssuePkg.sv
package dualIssuePkg;

    localparam int regCount = 32;

    // write-back data is carried at the default core width
    localparam int wbDataWidth = 32;

    typedef logic [4:0] regIdxT;

    // primary opcodes kept from the MIPS encoding
    typedef enum logic [5:0] {
        opRtype = 6'h00,
        opAddi  = 6'h08,
        opSlti  = 6'h0a,
        opAndi  = 6'h0c,
        opOri   = 6'h0d,
        opXori  = 6'h0e,
        opLui   = 6'h0f
    } opcodeT;

    // R-type function field
    typedef enum logic [5:0] {
        fnSll = 6'h00,
        fnSrl = 6'h02,
        fnSra = 6'h03,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnXor = 6'h26,
        fnNor = 6'h27,
        fnSlt = 6'h2a
    } functT;

    typedef enum logic [3:0] {
        aluSll = 4'd0,
        aluSrl = 4'd1,
        aluSra = 4'd2,
        aluAdd = 4'd3,
        aluSub = 4'd4,
        aluAnd = 4'd5,
        aluOr  = 4'd6,
        aluXor = 4'd7,
        aluNor = 4'd8,
        aluSlt = 4'd9,
        aluLui = 4'd10
    } aluOpT;

    // decoded control for one lane
    typedef struct packed {
        logic       regWe;
        aluOpT      aluOp;
        logic       aluSrcImm;
        regIdxT     dest;
        regIdxT     rs;
        regIdxT     rt;
        logic [4:0] shamt;
    } laneCtrlT;

    localparam int laneCtrlWidth = $bits(laneCtrlT);

    typedef struct packed {
        logic                   regWe;
        regIdxT                 dest;
        logic [wbDataWidth-1:0] data;
    } wbT;

endpackage

//--- design/registerFile.sv
module registerFile #(
    parameter int dataWidth = 32
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   enable,
    input  dualIssuePkg::regIdxT   readAddr1,
    input  dualIssuePkg::regIdxT   readAddr2,
    input  dualIssuePkg::regIdxT   readAddr3,
    input  dualIssuePkg::regIdxT   readAddr4,
    output logic [dataWidth-1:0]   readData1,
    output logic [dataWidth-1:0]   readData2,
    output logic [dataWidth-1:0]   readData3,
    output logic [dataWidth-1:0]   readData4,
    input  dualIssuePkg::wbT       wb1,
    input  dualIssuePkg::wbT       wb2
);
    import dualIssuePkg::*;

    logic [dataWidth-1:0] regs [regCount];

    // lane 2 is applied last so it wins on a shared destination
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (enable) begin
            if (wb1.regWe && wb1.dest != '0) begin
                regs[wb1.dest] <= dataWidth'(wb1.data);
            end
            if (wb2.regWe && wb2.dest != '0) begin
                regs[wb2.dest] <= dataWidth'(wb2.data);
            end
        end
    end

    // read with write-through, r0 always reads zero
    function automatic logic [dataWidth-1:0] readPort(regIdxT addr);
        logic [dataWidth-1:0] value;
        value = regs[addr];
        if (wb1.regWe && wb1.dest == addr) begin
            value = dataWidth'(wb1.data);
        end
        if (wb2.regWe && wb2.dest == addr) begin
            value = dataWidth'(wb2.data);
        end
        if (addr == '0) begin
            value = '0;
        end
        return value;
    endfunction

    always_comb begin
        readData1 = readPort(readAddr1);
        readData2 = readPort(readAddr2);
        readData3 = readPort(readAddr3);
        readData4 = readPort(readAddr4);
    end

endmodule

//--- design/laneDecoder.sv
module laneDecoder #(
    parameter int dataWidth = 32
) (
    input  logic [31:0]            instr,
    output dualIssuePkg::laneCtrlT ctrl,
    output logic [dataWidth-1:0]   imm
);
    import dualIssuePkg::*;

    opcodeT opcode;
    functT  funct;
    logic   zeroExt;

    assign opcode = opcodeT'(instr[31:26]);
    assign funct  = functT'(instr[5:0]);

    always_comb begin
        // I-type defaults, R-type overrides below
        ctrl.regWe     = 1'b1;
        ctrl.aluOp     = aluAdd;
        ctrl.aluSrcImm = 1'b1;
        ctrl.dest      = instr[20:16];
        ctrl.rs        = instr[25:21];
        ctrl.rt        = instr[20:16];
        ctrl.shamt     = instr[10:6];
        zeroExt        = 1'b0;
        case (opcode)
            opRtype: begin
                ctrl.aluSrcImm = 1'b0;
                ctrl.dest      = instr[15:11];
                case (funct)
                    fnSll:   ctrl.aluOp = aluSll;
                    fnSrl:   ctrl.aluOp = aluSrl;
                    fnSra:   ctrl.aluOp = aluSra;
                    fnAdd:   ctrl.aluOp = aluAdd;
                    fnSub:   ctrl.aluOp = aluSub;
                    fnAnd:   ctrl.aluOp = aluAnd;
                    fnOr:    ctrl.aluOp = aluOr;
                    fnXor:   ctrl.aluOp = aluXor;
                    fnNor:   ctrl.aluOp = aluNor;
                    fnSlt:   ctrl.aluOp = aluSlt;
                    default: ctrl.regWe = 1'b0;
                endcase
            end
            opAddi: ctrl.aluOp = aluAdd;
            opSlti: ctrl.aluOp = aluSlt;
            opAndi: begin
                ctrl.aluOp = aluAnd;
                zeroExt    = 1'b1;
            end
            opOri: begin
                ctrl.aluOp = aluOr;
                zeroExt    = 1'b1;
            end
            opXori: begin
                ctrl.aluOp = aluXor;
                zeroExt    = 1'b1;
            end
            opLui:  ctrl.aluOp = aluLui;
            default: ctrl.regWe = 1'b0;
        endcase
    end

    // logical immediates are zero-extended, the rest sign-extended
    assign imm = zeroExt ? dataWidth'(instr[15:0]) : dataWidth'($signed(instr[15:0]));

endmodule

//--- design/decodeStage.sv
module decodeStage #(
    parameter int dataWidth = 32
) (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic                                                 enable,
    input  logic                                                 bundleValid,
    input  logic [31:0]                                          instr1,
    input  logic [31:0]                                          instr2,
    input  dualIssuePkg::wbT                                     wb1,
    input  dualIssuePkg::wbT                                     wb2,
    output logic [dualIssuePkg::laneCtrlWidth+3*dataWidth-1:0] lane1,
    output logic [dualIssuePkg::laneCtrlWidth+3*dataWidth-1:0] lane2,
    output logic                                                 exValid
);
    import dualIssuePkg::*;

    typedef struct packed {
        laneCtrlT             ctrl;
        logic [dataWidth-1:0] opA;
        logic [dataWidth-1:0] opB;
        logic [dataWidth-1:0] imm;
    } laneExT;

    logic [31:0]          bundleInstr1;
    logic [31:0]          bundleInstr2;
    logic                 bundleHeld;
    laneCtrlT             ctrl1;
    laneCtrlT             ctrl2;
    logic [dataWidth-1:0] imm1;
    logic [dataWidth-1:0] imm2;
    logic [dataWidth-1:0] rsData1;
    logic [dataWidth-1:0] rtData1;
    logic [dataWidth-1:0] rsData2;
    logic [dataWidth-1:0] rtData2;
    laneExT               exLane1;
    laneExT               exLane2;

    // bundle register, only loaded on a strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            bundleHeld <= 1'b0;
        end else if (enable) begin
            bundleHeld <= bundleValid;
            if (bundleValid) begin
                bundleInstr1 <= instr1;
                bundleInstr2 <= instr2;
            end
        end
    end

    laneDecoder #(.dataWidth(dataWidth)) i_laneDec1 (
        .instr (bundleInstr1),
        .ctrl  (ctrl1),
        .imm   (imm1)
    );

    laneDecoder #(.dataWidth(dataWidth)) i_laneDec2 (
        .instr (bundleInstr2),
        .ctrl  (ctrl2),
        .imm   (imm2)
    );

    // both lanes see the register state from before the bundle
    registerFile #(.dataWidth(dataWidth)) i_regFile (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .readAddr1 (ctrl1.rs),
        .readAddr2 (ctrl1.rt),
        .readAddr3 (ctrl2.rs),
        .readAddr4 (ctrl2.rt),
        .readData1 (rsData1),
        .readData2 (rtData1),
        .readData3 (rsData2),
        .readData4 (rtData2),
        .wb1       (wb1),
        .wb2       (wb2)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            exValid <= 1'b0;
        end else if (enable) begin
            exValid <= bundleHeld;
            exLane1 <= '{ctrl: ctrl1, opA: rsData1, opB: rtData1, imm: imm1};
            exLane2 <= '{ctrl: ctrl2, opA: rsData2, opB: rtData2, imm: imm2};
        end
    end

    assign lane1 = exLane1;
    assign lane2 = exLane2;

    // a frozen pipe must not launch a bundle into execute
    assert property (@(posedge clk) disable iff (reset) $rose(exValid) |-> $past(enable));

endmodule

//--- design/laneAlu.sv
module laneAlu #(
    parameter int dataWidth = 32
) (
    input  logic [dataWidth-1:0] opA,
    input  logic [dataWidth-1:0] opB,
    input  logic [4:0]           shamt,
    input  dualIssuePkg::aluOpT  aluOp,
    output logic [dataWidth-1:0] result
);
    import dualIssuePkg::*;

    logic lessThan;

    assign lessThan = $signed(opA) < $signed(opB);

    // shifts act on the rt operand, as in MIPS
    always_comb begin
        case (aluOp)
            aluAdd:  result = opA + opB;
            aluSub:  result = opA - opB;
            aluAnd:  result = opA & opB;
            aluOr:   result = opA | opB;
            aluXor:  result = opA ^ opB;
            aluNor:  result = ~(opA | opB);
            aluSlt:  result = {{(dataWidth-1){1'b0}}, lessThan};
            aluSll:  result = opB << shamt;
            aluSrl:  result = opB >> shamt;
            aluSra:  result = $signed(opB) >>> shamt;
            aluLui:  result = opB << 16;
            default: result = '0;
        endcase
    end

endmodule

//--- design/executeStage.sv
module executeStage #(
    parameter int dataWidth = 32
) (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic                                                 enable,
    input  logic [dualIssuePkg::laneCtrlWidth+3*dataWidth-1:0] lane1,
    input  logic [dualIssuePkg::laneCtrlWidth+3*dataWidth-1:0] lane2,
    input  logic                                                 exValid,
    input  dualIssuePkg::wbT                                     fwd1,
    input  dualIssuePkg::wbT                                     fwd2,
    output dualIssuePkg::wbT                                     wbNext1,
    output dualIssuePkg::wbT                                     wbNext2,
    output logic                                                 wbValid
);
    import dualIssuePkg::*;

    typedef struct packed {
        laneCtrlT             ctrl;
        logic [dataWidth-1:0] opA;
        logic [dataWidth-1:0] opB;
        logic [dataWidth-1:0] imm;
    } laneExT;

    laneExT               ex1;
    laneExT               ex2;
    logic [dataWidth-1:0] srcA1;
    logic [dataWidth-1:0] srcB1;
    logic [dataWidth-1:0] srcA2;
    logic [dataWidth-1:0] srcB2;
    logic [dataWidth-1:0] aluB1;
    logic [dataWidth-1:0] aluB2;
    logic [dataWidth-1:0] aluOut1;
    logic [dataWidth-1:0] aluOut2;

    assign ex1 = lane1;
    assign ex2 = lane2;

    // youngest producer wins: own register lane 2, lane 1, then result lane 2, lane 1
    function automatic logic [dataWidth-1:0] pickOperand(regIdxT src,
                                                         logic [dataWidth-1:0] decoded);
        logic [dataWidth-1:0] value;
        value = decoded;
        if (src != '0) begin
            if (fwd1.regWe && fwd1.dest == src) begin
                value = dataWidth'(fwd1.data);
            end
            if (fwd2.regWe && fwd2.dest == src) begin
                value = dataWidth'(fwd2.data);
            end
            if (wbNext1.regWe && wbNext1.dest == src) begin
                value = dataWidth'(wbNext1.data);
            end
            if (wbNext2.regWe && wbNext2.dest == src) begin
                value = dataWidth'(wbNext2.data);
            end
        end
        return value;
    endfunction

    always_comb begin
        srcA1 = pickOperand(ex1.ctrl.rs, ex1.opA);
        srcB1 = pickOperand(ex1.ctrl.rt, ex1.opB);
        srcA2 = pickOperand(ex2.ctrl.rs, ex2.opA);
        srcB2 = pickOperand(ex2.ctrl.rt, ex2.opB);
        aluB1 = ex1.ctrl.aluSrcImm ? ex1.imm : srcB1;
        aluB2 = ex2.ctrl.aluSrcImm ? ex2.imm : srcB2;
    end

    laneAlu #(.dataWidth(dataWidth)) i_alu1 (
        .opA    (srcA1),
        .opB    (aluB1),
        .shamt  (ex1.ctrl.shamt),
        .aluOp  (ex1.ctrl.aluOp),
        .result (aluOut1)
    );

    laneAlu #(.dataWidth(dataWidth)) i_alu2 (
        .opA    (srcA2),
        .opB    (aluB2),
        .shamt  (ex2.ctrl.shamt),
        .aluOp  (ex2.ctrl.aluOp),
        .result (aluOut2)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            wbValid       <= 1'b0;
            wbNext1.regWe <= 1'b0;
            wbNext2.regWe <= 1'b0;
        end else if (enable) begin
            wbValid <= exValid;
            wbNext1 <= '{regWe: ex1.ctrl.regWe && exValid, dest: ex1.ctrl.dest,
                         data: wbDataWidth'(aluOut1)};
            wbNext2 <= '{regWe: ex2.ctrl.regWe && exValid, dest: ex2.ctrl.dest,
                         data: wbDataWidth'(aluOut2)};
        end
    end

    // the result stage never offers r0 as a forwarding source
    assert property (@(posedge clk) disable iff (reset)
        (fwd1.regWe || fwd2.regWe) |-> !(fwd1.regWe && fwd1.dest == '0)
                                       && !(fwd2.regWe && fwd2.dest == '0));

endmodule

//--- design/resultStage.sv
module resultStage (
    input  logic             clk,
    input  logic             reset,
    input  logic             enable,
    input  logic             wbValid,
    input  dualIssuePkg::wbT wbNext1,
    input  dualIssuePkg::wbT wbNext2,
    output dualIssuePkg::wbT result1,
    output dualIssuePkg::wbT result2,
    output logic             resultValid
);
    import dualIssuePkg::*;

    wbT   laneIn1;
    wbT   laneIn2;
    logic validHeld;

    always_comb begin
        laneIn1       = wbNext1;
        laneIn2       = wbNext2;
        laneIn1.regWe = wbNext1.regWe && wbValid && wbNext1.dest != '0;
        laneIn2.regWe = wbNext2.regWe && wbValid && wbNext2.dest != '0;
        // same destination in one bundle, lane 2 wins
        if (laneIn1.regWe && laneIn2.regWe && wbNext1.dest == wbNext2.dest) begin
            laneIn1.regWe = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            validHeld     <= 1'b0;
            result1.regWe <= 1'b0;
            result2.regWe <= 1'b0;
        end else if (enable) begin
            validHeld <= wbValid;
            result1   <= laneIn1;
            result2   <= laneIn2;
        end
    end

    assign resultValid = validHeld && enable;

    assert property (@(posedge clk) disable iff (reset)
        !(result1.regWe && result2.regWe && result1.dest == result2.dest));

endmodule

//--- design/dualIssueCore.sv
module dualIssueCore #(
    parameter int dataWidth = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             enable,
    input  logic             bundleValid,
    input  logic [31:0]      instr1,
    input  logic [31:0]      instr2,
    output dualIssuePkg::wbT result1,
    output dualIssuePkg::wbT result2,
    output logic             resultValid
);
    import dualIssuePkg::*;

    logic [laneCtrlWidth+3*dataWidth-1:0] lane1;
    logic [laneCtrlWidth+3*dataWidth-1:0] lane2;
    logic                                 exValid;
    wbT                                   wbNext1;
    wbT                                   wbNext2;
    logic                                 wbValid;

    decodeStage #(.dataWidth(dataWidth)) i_decode (
        .clk         (clk),
        .reset       (reset),
        .enable      (enable),
        .bundleValid (bundleValid),
        .instr1      (instr1),
        .instr2      (instr2),
        .wb1         (result1),
        .wb2         (result2),
        .lane1       (lane1),
        .lane2       (lane2),
        .exValid     (exValid)
    );

    executeStage #(.dataWidth(dataWidth)) i_execute (
        .clk     (clk),
        .reset   (reset),
        .enable  (enable),
        .lane1   (lane1),
        .lane2   (lane2),
        .exValid (exValid),
        .fwd1    (result1),
        .fwd2    (result2),
        .wbNext1 (wbNext1),
        .wbNext2 (wbNext2),
        .wbValid (wbValid)
    );

    resultStage i_result (
        .clk         (clk),
        .reset       (reset),
        .enable      (enable),
        .wbValid     (wbValid),
        .wbNext1     (wbNext1),
        .wbNext2     (wbNext2),
        .result1     (result1),
        .result2     (result2),
        .resultValid (resultValid)
    );

endmodule

//--- dv/coreTb.sv
module coreTb;
    timeunit 1ns;
    timeprecision 100ps;
    import dualIssuePkg::*;

    localparam logic [31:0] seed = 32'hf645e315;
    localparam int issueTimeout = 50;
    localparam int drainTimeout = 100;

    // expected write-back pair for one bundle
    typedef struct packed {
        wbT lane1;
        wbT lane2;
    } expectT;

    logic        clk;
    logic        reset;
    logic        enable;
    logic        bundleValid;
    logic [31:0] instr1;
    logic [31:0] instr2;
    wbT          result1;
    wbT          result2;
    logic        resultValid;

    logic [31:0] modelRegs [regCount];
    expectT      expectQueue [$];
    logic [31:0] stimState;
    logic [31:0] enableState;
    logic        toggleEnable;
    logic        aborted;
    int          errorCount;
    int          checkCount;
    int          bundleCount;
    int          testErrors;
    int          testChecks;

    dualIssueCore #(.dataWidth(32)) i_dut (
        .clk         (clk),
        .reset       (reset),
        .enable      (enable),
        .bundleValid (bundleValid),
        .instr1      (instr1),
        .instr2      (instr2),
        .result1     (result1),
        .result2     (result2),
        .resultValid (resultValid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcgStep(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // enable goes low on random cycles while toggling is on
    initial begin
        enable      = 1'b1;
        enableState = seed;
        forever begin
            @(negedge clk);
            if (toggleEnable) begin
                enableState = lcgStep(enableState);
                enable      = enableState[31:30] != 2'b00;
            end else begin
                enable = 1'b1;
            end
        end
    end

    function automatic logic [31:0] rType(input logic [5:0] funct, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] shamt);
        return {6'h00, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] opcode, input logic [4:0] rt,
                                           input logic [4:0] rs, input logic [15:0] imm);
        return {opcode, rs, rt, imm};
    endfunction

    // MIPS semantics of one lane against the register state before the bundle
    function automatic wbT modelLane(input logic [31:0] instr);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immS;
        logic [31:0] immZ;
        logic [4:0]  shamt;
        wbT          lane;
        a     = modelRegs[instr[25:21]];
        b     = modelRegs[instr[20:16]];
        immS  = {{16{instr[15]}}, instr[15:0]};
        immZ  = {16'h0000, instr[15:0]};
        shamt = instr[10:6];
        lane  = '{regWe: 1'b1, dest: instr[20:16], data: '0};
        case (instr[31:26])
            6'h00: begin
                lane.dest = instr[15:11];
                case (instr[5:0])
                    6'h00:   lane.data = b << shamt;
                    6'h02:   lane.data = b >> shamt;
                    6'h03:   lane.data = $signed(b) >>> shamt;
                    6'h20:   lane.data = a + b;
                    6'h22:   lane.data = a - b;
                    6'h24:   lane.data = a & b;
                    6'h25:   lane.data = a | b;
                    6'h26:   lane.data = a ^ b;
                    6'h27:   lane.data = ~(a | b);
                    6'h2a:   lane.data = {31'd0, $signed(a) < $signed(b)};
                    default: lane.regWe = 1'b0;
                endcase
            end
            6'h08:   lane.data = a + immS;
            6'h0a:   lane.data = {31'd0, $signed(a) < $signed(immS)};
            6'h0c:   lane.data = a & immZ;
            6'h0d:   lane.data = a | immZ;
            6'h0e:   lane.data = a ^ immZ;
            6'h0f:   lane.data = {instr[15:0], 16'h0000};
            default: lane.regWe = 1'b0;
        endcase
        // r0 is hard-wired to zero
        if (lane.dest == 5'd0) begin
            lane.regWe = 1'b0;
        end
        return lane;
    endfunction

    function automatic expectT modelBundle(input logic [31:0] first, input logic [31:0] second);
        expectT pair;
        pair.lane1 = modelLane(first);
        pair.lane2 = modelLane(second);
        // the later lane wins a shared destination
        if (pair.lane1.regWe && pair.lane2.regWe && pair.lane1.dest == pair.lane2.dest) begin
            pair.lane1.regWe = 1'b0;
        end
        return pair;
    endfunction

    // kinds 0 to 9 pick an R-type function and 10 to 15 an I-type opcode
    task automatic makeInstr(input int kind, input logic [4:0] regMask,
                             output logic [31:0] instr);
        logic [5:0]  functCodes [10];
        logic [5:0]  opCodes [6];
        logic [31:0] fields;
        logic [31:0] immBits;
        functCodes = '{6'h00, 6'h02, 6'h03, 6'h20, 6'h22, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a};
        opCodes    = '{6'h08, 6'h0a, 6'h0c, 6'h0d, 6'h0e, 6'h0f};
        stimState  = lcgStep(stimState);
        fields     = stimState;
        stimState  = lcgStep(stimState);
        immBits    = stimState;
        if (kind < 10) begin
            instr = rType(functCodes[kind], fields[31:27] & regMask, fields[26:22] & regMask,
                          fields[21:17] & regMask, fields[16:12]);
        end else begin
            instr = iType(opCodes[kind-10], fields[31:27] & regMask, fields[26:22] & regMask,
                          immBits[31:16]);
        end
    endtask

    task automatic issueBundle(input logic [31:0] first, input logic [31:0] second);
        expectT pair;
        int     waitCycles;
        if (aborted) begin
            return;
        end
        pair = modelBundle(first, second);
        if (pair.lane1.regWe) begin
            modelRegs[pair.lane1.dest] = pair.lane1.data;
        end
        if (pair.lane2.regWe) begin
            modelRegs[pair.lane2.dest] = pair.lane2.data;
        end
        expectQueue.push_back(pair);
        bundleCount++;
        @(negedge clk);
        instr1      = first;
        instr2      = second;
        bundleValid = 1'b1;
        // the strobe is only taken on an edge with enable high
        @(posedge clk);
        waitCycles = 0;
        while (!enable && waitCycles < issueTimeout) begin
            @(posedge clk);
            waitCycles++;
        end
        if (!enable) begin
            $display("Timeout: bundle not accepted, enable stayed low for %0d cycles",
                     issueTimeout);
            errorCount++;
            aborted = 1'b1;
        end
    endtask

    task automatic randomBundles(input int count, input logic [4:0] regMask);
        logic [31:0] first;
        logic [31:0] second;
        for (int n = 0; n < count; n++) begin
            stimState = lcgStep(stimState);
            makeInstr(stimState[31:28], regMask, first);
            stimState = lcgStep(stimState);
            makeInstr(stimState[31:28], regMask, second);
            issueBundle(first, second);
        end
    endtask

    task automatic drainResults();
        int waitCycles;
        if (aborted) begin
            return;
        end
        @(negedge clk);
        bundleValid = 1'b0;
        waitCycles  = 0;
        while (expectQueue.size() != 0 && waitCycles < drainTimeout) begin
            @(negedge clk);
            waitCycles++;
        end
        if (expectQueue.size() != 0) begin
            $display("Timeout: no result arrived for %0d outstanding bundles within %0d cycles",
                     expectQueue.size(), drainTimeout);
            errorCount++;
            aborted = 1'b1;
        end
    endtask

    task automatic startTest();
        testErrors = errorCount;
        testChecks = checkCount;
    endtask

    task automatic endTest(input string name);
        drainResults();
        $display("%s: %0d checks, %0d errors", name, checkCount - testChecks,
                 errorCount - testErrors);
    endtask

    task automatic compareLane(input string name, input wbT got, input wbT expected);
        checkCount++;
        assert (got.regWe == expected.regWe) else begin
            $display("Mismatch %s.regWe: got 0x%h, expected 0x%h", name, got.regWe,
                     expected.regWe);
            errorCount++;
        end
        // dest and data only matter for a lane that writes
        if (expected.regWe) begin
            checkCount++;
            assert (got.dest == expected.dest) else begin
                $display("Mismatch %s.dest: got 0x%h, expected 0x%h", name, got.dest,
                         expected.dest);
                errorCount++;
            end
            checkCount++;
            assert (got.data == expected.data) else begin
                $display("Mismatch %s.data: got 0x%h, expected 0x%h", name, got.data,
                         expected.data);
                errorCount++;
            end
        end
    endtask

    always @(posedge clk) begin : compareResults
        expectT expected;
        if (!reset) begin
            if (!enable) begin
                checkCount++;
                assert (!resultValid) else begin
                    $display("resultValid high while enable is low");
                    errorCount++;
                end
            end
            if (resultValid) begin
                checkCount++;
                assert (expectQueue.size() != 0) else begin
                    $display("resultValid high with no bundle outstanding");
                    errorCount++;
                end
                if (expectQueue.size() != 0) begin
                    expected = expectQueue.pop_front();
                    compareLane("result1", result1, expected.lane1);
                    compareLane("result2", result2, expected.lane2);
                end
            end
        end
    end

    initial begin
        logic [31:0] first;
        logic [31:0] second;
        reset        = 1'b1;
        bundleValid  = 1'b0;
        instr1       = '0;
        instr2       = '0;
        toggleEnable = 1'b0;
        aborted      = 1'b0;
        stimState    = seed;
        errorCount   = 0;
        checkCount   = 0;
        bundleCount  = 0;
        for (int i = 0; i < regCount; i++) begin
            modelRegs[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        startTest();
        for (int n = 0; n < 12; n++) begin
            @(negedge clk);
            checkCount++;
            assert (!resultValid) else begin
                $display("resultValid high with no bundle issued");
                errorCount++;
            end
        end
        issueBundle(rType(6'h20, 5'd1, 5'd2, 5'd3, 5'd0),
                    rType(6'h25, 5'd4, 5'd5, 5'd6, 5'd0));
        issueBundle(iType(6'h08, 5'd7, 5'd8, 16'h0000), iType(6'h0d, 5'd9, 5'd31, 16'h0000));
        endTest("test 1 idle after reset");

        startTest();
        for (int k = 0; k < 16; k++) begin
            makeInstr(k, 5'h1f, first);
            makeInstr(15 - k, 5'h1f, second);
            issueBundle(first, second);
        end
        randomBundles(30, 5'h1f);
        endTest("test 2 random independent bundles");

        startTest();
        issueBundle(iType(6'h08, 5'd1, 5'd0, 16'h0011), iType(6'h08, 5'd2, 5'd0, 16'hfff0));
        issueBundle(rType(6'h20, 5'd3, 5'd1, 5'd2, 5'd0),
                    rType(6'h22, 5'd4, 5'd2, 5'd1, 5'd0));
        issueBundle(rType(6'h2a, 5'd1, 5'd4, 5'd3, 5'd0),
                    rType(6'h03, 5'd2, 5'd0, 5'd4, 5'd3));
        // lane 2 copies lane 1's destination and must see the older value
        issueBundle(iType(6'h0d, 5'd3, 5'd3, 16'h8000),
                    rType(6'h20, 5'd4, 5'd3, 5'd0, 5'd0));
        randomBundles(40, 5'h03);
        randomBundles(40, 5'h07);
        endTest("test 3 dependent back-to-back bundles");

        startTest();
        issueBundle(iType(6'h08, 5'd5, 5'd0, 16'h0111), iType(6'h08, 5'd5, 5'd0, 16'h0222));
        issueBundle(rType(6'h20, 5'd8, 5'd5, 5'd5, 5'd0),
                    rType(6'h22, 5'd8, 5'd0, 5'd5, 5'd0));
        issueBundle(iType(6'h08, 5'd0, 5'd5, 16'h0055), iType(6'h0d, 5'd0, 5'd8, 16'h00ff));
        issueBundle(rType(6'h20, 5'd9, 5'd0, 5'd8, 5'd0),
                    rType(6'h27, 5'd0, 5'd8, 5'd8, 5'd0));
        drainResults();
        issueBundle(rType(6'h25, 5'd10, 5'd5, 5'd0, 5'd0),
                    rType(6'h20, 5'd11, 5'd8, 5'd0, 5'd0));
        endTest("test 4 shared destination and r0 writes");

        startTest();
        toggleEnable = 1'b1;
        randomBundles(40, 5'h07);
        toggleEnable = 1'b0;
        endTest("test 5 enable toggling");

        startTest();
        issueBundle(iType(6'h08, 5'd12, 5'd0, 16'h1234), iType(6'h08, 5'd13, 5'd0, 16'h5678));
        // load, store, addiu, beq and j are outside the kept set
        issueBundle(iType(6'h23, 5'd12, 5'd0, 16'h0004), iType(6'h2b, 5'd13, 5'd0, 16'h0008));
        issueBundle(iType(6'h09, 5'd12, 5'd12, 16'h0001), iType(6'h04, 5'd13, 5'd12, 16'h0003));
        issueBundle(rType(6'h21, 5'd12, 5'd13, 5'd13, 5'd0),
                    rType(6'h2b, 5'd13, 5'd12, 5'd12, 5'd0));
        issueBundle(rType(6'h08, 5'd12, 5'd13, 5'd0, 5'd0), iType(6'h02, 5'd13, 5'd0, 16'h0010));
        issueBundle(rType(6'h20, 5'd14, 5'd12, 5'd0, 5'd0),
                    rType(6'h20, 5'd15, 5'd13, 5'd0, 5'd0));
        endTest("test 6 unlisted encodings");

        repeat (5) @(negedge clk);
        $display("Summary: %0d bundles, %0d checks, %0d errors", bundleCount, checkCount,
                 errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- sim.f
design/dualIssuePkg.sv
design/registerFile.sv
design/laneDecoder.sv
design/decodeStage.sv
design/laneAlu.sv
design/executeStage.sv
design/resultStage.sv
design/dualIssueCore.sv
dv/coreTb.sv
